// File: rob_config.svh
`ifndef ROB_CONFIG_SVH
`define ROB_CONFIG_SVH

// total entries split evenly over the banks
`define ROB_DEPTH      16
// one bank per dispatch and commit lane
`define ROB_BANKS      2
`define ROB_BANK_DEPTH (`ROB_DEPTH / `ROB_BANKS)

// common writeback ports
`define WB_PORTS       2

// payload field widths
`define PC_W           32
`define AREG_W         5
`define PREG_W         6
`define CAUSE_W        5

// index widths derived from the sizes above
`define ROB_SLOT_W     ($clog2(`ROB_BANK_DEPTH))
`define ROB_BSEL_W     ($clog2(`ROB_BANKS))
`define ROB_IDX_W      ($clog2(`ROB_DEPTH) + 1)
`define ROB_CNT_W      ($clog2(`ROB_DEPTH + 1))

`endif

// File: rob_pkg.sv
`default_nettype none

`include "rob_config.svh"

package rob_pkg;

    // wrap flag on top and bank select at the bottom so the whole word counts in program order
    typedef struct packed {
        logic                   wrap;
        logic [`ROB_SLOT_W-1:0] slot;
        logic [`ROB_BSEL_W-1:0] bank;
    } rob_idx_t;

    typedef struct packed {
        logic [`PC_W-1:0]   pc;
        logic               has_rd;
        logic [`AREG_W-1:0] areg;
        logic [`PREG_W-1:0] preg;
        logic [`PREG_W-1:0] old_preg;
        // moves and nops are finished as soon as they are written
        logic               done_at_enq;
    } rob_entry_t;

    typedef struct packed {
        logic     valid;
        rob_idx_t idx;
    } wb_t;

    typedef enum logic [1:0] {
        spec_none    = 2'd0,
        spec_mispred = 2'd1,
        spec_except  = 2'd2
    } spec_kind_e;

    // npc bit 0 is always zero, so only the upper bits travel
    typedef struct packed {
        logic             taken;
        logic [`PC_W-2:0] npc_hi;
    } br_view_t;

    typedef struct packed {
        logic [`CAUSE_W-1:0]      cause;
        logic [`PC_W-`CAUSE_W-1:0] tval;
    } exc_view_t;

    typedef union packed {
        br_view_t  br;
        exc_view_t exc;
    } spec_payload_u;

    typedef struct packed {
        logic          valid;
        spec_kind_e    kind;
        rob_idx_t      idx;
        spec_payload_u payload;
    } spec_wb_t;

    typedef struct packed {
        logic               has_rd;
        logic [`AREG_W-1:0] areg;
        logic [`PREG_W-1:0] preg;
        logic [`PREG_W-1:0] old_preg;
    } commit_info_t;

    typedef struct packed {
        logic       valid;
        logic       finished;
        rob_entry_t entry;
        rob_idx_t   idx;
    } bank_head_t;

    typedef struct packed {
        logic                is_except;
        logic [`PC_W-1:0]    target_pc;
        logic [`PC_W-1:0]    epc;
        logic [`CAUSE_W-1:0] cause;
    } squash_info_t;

endpackage

`default_nettype wire

// File: rob_alloc.sv
`timescale 1ns/1ns
`default_nettype none

`include "rob_config.svh"

module rob_alloc import rob_pkg::*; (
    input  wire                       clk,
    input  wire                       rst,
    // dispatch side
    input  wire                       i_enq_vld,
    input  wire [`ROB_BANKS-1:0]      i_enq_req,
    input  wire rob_entry_t           i_enq_entry [`ROB_BANKS],
    // slots released by commit this cycle
    input  wire [`ROB_CNT_W-1:0]      i_free_cnt,
    input  wire                       i_squash,
    output logic                      o_can_enq,
    output rob_idx_t                  o_alloc_idx [`ROB_BANKS],
    // per bank write port
    output logic [`ROB_BANKS-1:0]     o_bank_wr,
    output logic [`ROB_SLOT_W-1:0]    o_bank_slot [`ROB_BANKS],
    output rob_entry_t                o_bank_entry [`ROB_BANKS]
);

    // tail counts in program order and its low bits select the bank
    logic [`ROB_IDX_W-1:0] tail;
    logic [`ROB_CNT_W-1:0] free_cnt;
    logic [`ROB_CNT_W-1:0] enq_cnt;
    logic                  fire;

    // room for a full dispatch group, and nothing accepted while squashing
    assign o_can_enq = (free_cnt >= (`ROB_CNT_W)'(`ROB_BANKS)) && !i_squash;
    assign fire      = i_enq_vld && o_can_enq;

    always_comb begin
        logic [`ROB_IDX_W-1:0] lane_ptr;
        rob_idx_t              lane_idx;
        enq_cnt = '0;
        o_bank_wr = '0;
        for (int b = 0; b < `ROB_BANKS; b++) begin
            o_bank_slot[b]  = '0;
            o_bank_entry[b] = '0;
        end
        for (int k = 0; k < `ROB_BANKS; k++) begin
            lane_ptr       = tail + (`ROB_IDX_W)'(k);
            lane_idx       = rob_idx_t'(lane_ptr);
            o_alloc_idx[k] = lane_idx;
            // lane k lands in bank (tail bank + k)
            if (fire && i_enq_req[k]) begin
                o_bank_wr[lane_idx.bank]    = 1'b1;
                o_bank_slot[lane_idx.bank]  = lane_idx.slot;
                o_bank_entry[lane_idx.bank] = i_enq_entry[k];
                enq_cnt = enq_cnt + (`ROB_CNT_W)'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || i_squash) begin
            tail     <= '0;
            free_cnt <= (`ROB_CNT_W)'(`ROB_DEPTH);
        end else begin
            tail     <= tail + enq_cnt;
            free_cnt <= free_cnt - enq_cnt + i_free_cnt;
        end
    end

endmodule

`default_nettype wire

// File: rob_bank.sv
`timescale 1ns/1ns
`default_nettype none

`include "rob_config.svh"

module rob_bank import rob_pkg::*; #(
    parameter int unsigned BANK_ID = 0
) (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    i_flush,
    // write from the allocator
    input  wire                    i_wr,
    input  wire [`ROB_SLOT_W-1:0]  i_wr_slot,
    input  wire rob_entry_t        i_wr_entry,
    // common writeback shared by all banks
    input  wire wb_t               i_wb [`WB_PORTS],
    // head view toward commit
    input  wire                    i_pop,
    output bank_head_t             o_head
);

    localparam logic [`ROB_BSEL_W-1:0] BANK_SEL = (`ROB_BSEL_W)'(BANK_ID);

    rob_entry_t                 entries [`ROB_BANK_DEPTH];
    logic [`ROB_BANK_DEPTH-1:0] valid_q;
    logic [`ROB_BANK_DEPTH-1:0] finished_q;
    logic [`ROB_SLOT_W-1:0]     head_slot;
    logic                       head_wrap;

    // entry payload
    always_ff @(posedge clk) begin
        if (i_wr) begin
            entries[i_wr_slot] <= i_wr_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            valid_q    <= '0;
            finished_q <= '0;
            head_slot  <= '0;
            head_wrap  <= 1'b0;
        end else begin
            if (i_pop) begin
                valid_q[head_slot]    <= 1'b0;
                finished_q[head_slot] <= 1'b0;
                // wrap flag flips each time the slot rolls over
                {head_wrap, head_slot} <= {head_wrap, head_slot} + 1'b1;
            end
            for (int p = 0; p < `WB_PORTS; p++) begin
                if (i_wb[p].valid && (i_wb[p].idx.bank == BANK_SEL)) begin
                    finished_q[i_wb[p].idx.slot] <= 1'b1;
                end
            end
            // a fresh entry starts unfinished unless it needs no execution
            if (i_wr) begin
                valid_q[i_wr_slot]    <= 1'b1;
                finished_q[i_wr_slot] <= i_wr_entry.done_at_enq;
            end
        end
    end

    // oldest entry of this bank
    always_comb begin
        o_head.valid    = valid_q[head_slot];
        o_head.finished = finished_q[head_slot];
        o_head.entry    = entries[head_slot];
        o_head.idx.wrap = head_wrap;
        o_head.idx.slot = head_slot;
        o_head.idx.bank = BANK_SEL;
    end

endmodule

`default_nettype wire

// File: rob_commit.sv
`timescale 1ns/1ns
`default_nettype none

`include "rob_config.svh"

module rob_commit import rob_pkg::*; (
    input  wire                    clk,
    input  wire                    rst,
    input  wire bank_head_t        i_head [`ROB_BANKS],
    input  wire spec_wb_t          i_spec_wb,
    input  wire [`PC_W-1:0]        i_trap_vec,
    output logic [`ROB_BANKS-1:0]  o_pop,
    output logic [`ROB_CNT_W-1:0]  o_free_cnt,
    // lane 0 is always the oldest committed entry
    output logic [`ROB_BANKS-1:0]  o_commit_vld,
    output commit_info_t           o_commit_info [`ROB_BANKS],
    output logic                   o_squash_vld,
    output squash_info_t           o_squash_info
);

    typedef enum logic {
        st_normal,
        st_trap
    } commit_state_e;

    logic [`ROB_IDX_W-1:0] head_ptr;
    rob_idx_t              head_idx;
    commit_state_e         state;

    // oldest pending squash reason
    spec_kind_e            rec_kind;
    rob_idx_t              rec_idx;
    spec_payload_u         rec_payload;

    logic                  has_mispred;
    logic                  has_except;
    logic [`PC_W-1:0]      except_pc;
    logic [`PC_W-1:0]      trap_epc;
    logic                  rec_take;

    // distance from the commit head where smaller means older
    function automatic logic [`ROB_IDX_W-1:0] age_of(
        input rob_idx_t              idx,
        input logic [`ROB_IDX_W-1:0] head
    );
        logic [`ROB_IDX_W-1:0] raw;
        raw = idx;
        return raw - head;
    endfunction

    assign head_idx = rob_idx_t'(head_ptr);

    assign rec_take = i_spec_wb.valid && (i_spec_wb.kind != spec_none) &&
                      ((rec_kind == spec_none) ||
                       (age_of(i_spec_wb.idx, head_ptr) < age_of(rec_idx, head_ptr)));

    // walk the banks from the head bank in program order
    always_comb begin
        logic                   go;
        logic                   rec_hit;
        logic [`ROB_BSEL_W-1:0] b;
        go          = !o_squash_vld && (state == st_normal);
        has_mispred = 1'b0;
        has_except  = 1'b0;
        except_pc   = i_head[head_idx.bank].entry.pc;
        o_pop        = '0;
        o_commit_vld = '0;
        o_free_cnt   = '0;
        for (int k = 0; k < `ROB_BANKS; k++) begin
            b       = head_idx.bank + (`ROB_BSEL_W)'(k);
            rec_hit = i_head[b].valid && (i_head[b].idx == rec_idx);
            // an excepting entry never retires so commit stops in front of it
            if (go && rec_hit && (rec_kind == spec_except)) begin
                has_except = 1'b1;
                except_pc  = i_head[b].entry.pc;
                go         = 1'b0;
            end
            go = go && i_head[b].valid && i_head[b].finished;
            o_commit_vld[k] = go;
            o_pop[b]        = go;
            o_commit_info[k].has_rd   = i_head[b].entry.has_rd;
            o_commit_info[k].areg     = i_head[b].entry.areg;
            o_commit_info[k].preg     = i_head[b].entry.preg;
            o_commit_info[k].old_preg = i_head[b].entry.old_preg;
            if (go) begin
                o_free_cnt = o_free_cnt + (`ROB_CNT_W)'(1);
            end
            // the mispredicted branch retires while everything younger waits for the squash
            if (go && rec_hit && (rec_kind == spec_mispred)) begin
                has_mispred = 1'b1;
                go          = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || o_squash_vld) begin
            head_ptr     <= '0;
            rec_kind     <= spec_none;
            state        <= st_normal;
            o_squash_vld <= 1'b0;
        end else begin
            head_ptr <= head_ptr + o_free_cnt;
            if (rec_take) begin
                rec_kind <= i_spec_wb.kind;
            end
            case (state)
                st_normal: begin
                    if (has_except) begin
                        state <= st_trap;
                    end else if (has_mispred) begin
                        o_squash_vld <= 1'b1;
                    end
                end
                st_trap: begin
                    o_squash_vld <= 1'b1;
                end
                default: begin
                    state <= st_normal;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rec_take) begin
            rec_idx     <= i_spec_wb.idx;
            rec_payload <= i_spec_wb.payload;
        end
        if ((state == st_normal) && has_except) begin
            trap_epc <= except_pc;
        end
        // the union is read as branch or exception info by the record kind
        if (state == st_trap) begin
            o_squash_info.is_except <= 1'b1;
            o_squash_info.target_pc <= i_trap_vec;
            o_squash_info.epc       <= trap_epc;
            o_squash_info.cause     <= rec_payload.exc.cause;
        end else if (has_mispred) begin
            o_squash_info.is_except <= 1'b0;
            o_squash_info.target_pc <= {rec_payload.br.npc_hi, 1'b0};
            o_squash_info.epc       <= '0;
            o_squash_info.cause     <= '0;
        end
    end

endmodule

`default_nettype wire

// File: rob_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "rob_config.svh"

module rob_top import rob_pkg::*; (
    input  wire                    clk,
    input  wire                    rst,
    // dispatch
    input  wire                    i_enq_vld,
    input  wire [`ROB_BANKS-1:0]   i_enq_req,
    input  wire rob_entry_t        i_enq_entry [`ROB_BANKS],
    output logic                   o_can_enq,
    output rob_idx_t               o_alloc_idx [`ROB_BANKS],
    // writeback
    input  wire wb_t               i_wb [`WB_PORTS],
    input  wire spec_wb_t          i_spec_wb,
    input  wire [`PC_W-1:0]        i_trap_vec,
    // retire toward rename
    output logic [`ROB_BANKS-1:0]  o_commit_vld,
    output commit_info_t           o_commit_info [`ROB_BANKS],
    // pipeline squash
    output logic                   o_squash_vld,
    output squash_info_t           o_squash_info
);

    logic [`ROB_BANKS-1:0]  bank_wr;
    logic [`ROB_SLOT_W-1:0] bank_slot [`ROB_BANKS];
    rob_entry_t             bank_entry [`ROB_BANKS];
    bank_head_t             bank_head [`ROB_BANKS];
    logic [`ROB_BANKS-1:0]  bank_pop;
    logic [`ROB_CNT_W-1:0]  free_cnt;

    rob_alloc alloc_i (
        .clk          (clk),
        .rst          (rst),
        .i_enq_vld    (i_enq_vld),
        .i_enq_req    (i_enq_req),
        .i_enq_entry  (i_enq_entry),
        .i_free_cnt   (free_cnt),
        .i_squash     (o_squash_vld),
        .o_can_enq    (o_can_enq),
        .o_alloc_idx  (o_alloc_idx),
        .o_bank_wr    (bank_wr),
        .o_bank_slot  (bank_slot),
        .o_bank_entry (bank_entry)
    );

    for (genvar g = 0; g < `ROB_BANKS; g++) begin : gen_bank
        rob_bank #(
            .BANK_ID (g)
        ) bank_i (
            .clk        (clk),
            .rst        (rst),
            .i_flush    (o_squash_vld),
            .i_wr       (bank_wr[g]),
            .i_wr_slot  (bank_slot[g]),
            .i_wr_entry (bank_entry[g]),
            .i_wb       (i_wb),
            .i_pop      (bank_pop[g]),
            .o_head     (bank_head[g])
        );
    end

    rob_commit commit_i (
        .clk           (clk),
        .rst           (rst),
        .i_head        (bank_head),
        .i_spec_wb     (i_spec_wb),
        .i_trap_vec    (i_trap_vec),
        .o_pop         (bank_pop),
        .o_free_cnt    (free_cnt),
        .o_commit_vld  (o_commit_vld),
        .o_commit_info (o_commit_info),
        .o_squash_vld  (o_squash_vld),
        .o_squash_info (o_squash_info)
    );

endmodule

`default_nettype wire

// File: rob_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "rob_config.svh"

module rob_tb import rob_pkg::*; ();

    localparam int TEST_CNT        = 6;
    localparam int CYCLES_PER_TEST = 100;
    // waits on o_can_enq and on squash pulses can stretch a test well past its nominal length
    localparam int TIMEOUT_CYCLES  = TEST_CNT * CYCLES_PER_TEST + 1400;
    localparam logic [`PC_W-1:0] TRAP_VEC = 32'h0000_0100;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  i_enq_vld;
    logic [`ROB_BANKS-1:0] i_enq_req;
    rob_entry_t            i_enq_entry [`ROB_BANKS];
    logic                  o_can_enq;
    rob_idx_t              o_alloc_idx [`ROB_BANKS];
    wb_t                   i_wb [`WB_PORTS];
    spec_wb_t              i_spec_wb;
    logic [`PC_W-1:0]      i_trap_vec;
    logic [`ROB_BANKS-1:0] o_commit_vld;
    commit_info_t          o_commit_info [`ROB_BANKS];
    logic                  o_squash_vld;
    squash_info_t          o_squash_info;

    // dispatched entries in program order with the next to retire at the front
    rob_entry_t   expected_q [$];
    int           wb_todo [$];
    int           seed = 49;
    int           errors = 0;
    int           cycle = 0;
    int           next_seq = 0;
    int           tag = 0;
    int           commit_total = 0;
    int           dual_cnt = 0;
    int           last_commit_cycle = 0;
    int           squash_cnt = 0;
    int           squash_cycle = 0;
    squash_info_t squash_seen;

    always #5 clk = ~clk;

    rob_top dut_i (
        .clk           (clk),
        .rst           (rst),
        .i_enq_vld     (i_enq_vld),
        .i_enq_req     (i_enq_req),
        .i_enq_entry   (i_enq_entry),
        .o_can_enq     (o_can_enq),
        .o_alloc_idx   (o_alloc_idx),
        .i_wb          (i_wb),
        .i_spec_wb     (i_spec_wb),
        .i_trap_vec    (i_trap_vec),
        .o_commit_vld  (o_commit_vld),
        .o_commit_info (o_commit_info),
        .o_squash_vld  (o_squash_vld),
        .o_squash_info (o_squash_info)
    );

    task automatic expect_eq(input string name, input logic [63:0] got, input logic [63:0] want);
        assert (got === want) else begin
            errors++;
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h at cycle %0d", name, got, want, cycle);
        end
    endtask

    task automatic expect_true(input bit cond, input string what);
        assert (cond) else begin
            errors++;
            $display("error at cycle %0d: %s", cycle, what);
        end
    endtask

    // maps a program order number onto bank, slot and wrap flag
    function automatic rob_idx_t expected_idx(input int seq);
        rob_idx_t r;
        r.bank = (`ROB_BSEL_W)'(seq % `ROB_BANKS);
        r.slot = (`ROB_SLOT_W)'((seq / `ROB_BANKS) % `ROB_BANK_DEPTH);
        r.wrap = 1'((seq / `ROB_DEPTH) % 2);
        return r;
    endfunction

    function automatic rob_entry_t new_entry(input bit done);
        rob_entry_t e;
        tag++;
        e.pc          = 32'h0000_1000 + 32'(tag * 4);
        e.has_rd      = (tag % 3) != 0;
        e.areg        = (`AREG_W)'(tag + 1);
        e.preg        = (`PREG_W)'(tag + 8);
        e.old_preg    = (`PREG_W)'(tag + 33);
        e.done_at_enq = done;
        return e;
    endfunction

    function automatic spec_payload_u branch_payload(input logic [`PC_W-1:0] npc);
        spec_payload_u p;
        p.br.taken  = 1'b1;
        p.br.npc_hi = npc[`PC_W-1:1];
        return p;
    endfunction

    function automatic spec_payload_u except_payload(input logic [`CAUSE_W-1:0] cause);
        spec_payload_u p;
        p.exc.cause = cause;
        p.exc.tval  = (`PC_W-`CAUSE_W)'(32'h0bad_c0de);
        return p;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic dispatch_group(input rob_entry_t e0, input rob_entry_t e1, input int n);
        while (!o_can_enq) next_cycle();
        i_enq_vld      = 1'b1;
        i_enq_req      = (`ROB_BANKS)'((1 << n) - 1);
        i_enq_entry[0] = e0;
        i_enq_entry[1] = e1;
        #1;
        for (int k = 0; k < n; k++) begin
            expect_eq("o_alloc_idx", o_alloc_idx[k], expected_idx(next_seq + k));
        end
        expected_q.push_back(e0);
        if (n > 1) expected_q.push_back(e1);
        next_cycle();
        i_enq_vld = 1'b0;
        i_enq_req = '0;
        next_seq += n;
    endtask

    // drains wb_todo over the common ports in list order or at random
    task automatic writeback(input bit shuffle);
        int pick;
        while (wb_todo.size() > 0) begin
            for (int p = 0; p < `WB_PORTS; p++) begin
                i_wb[p] = '0;
                if (wb_todo.size() > 0) begin
                    pick = shuffle ? int'($unsigned($random(seed)) % wb_todo.size()) : 0;
                    i_wb[p].valid = 1'b1;
                    i_wb[p].idx   = expected_idx(wb_todo[pick]);
                    wb_todo.delete(pick);
                end
            end
            next_cycle();
        end
        for (int p = 0; p < `WB_PORTS; p++) i_wb[p] = '0;
    endtask

    task automatic report_spec(input spec_kind_e kind, input int seq, input spec_payload_u p);
        i_spec_wb.valid   = 1'b1;
        i_spec_wb.kind    = kind;
        i_spec_wb.idx     = expected_idx(seq);
        i_spec_wb.payload = p;
        next_cycle();
        i_spec_wb = '0;
    endtask

    task automatic wait_commits(input int target);
        while (commit_total < target) next_cycle();
    endtask

    task automatic wait_squash(input int target);
        while (squash_cnt < target) next_cycle();
    endtask

    // younger entries are thrown away and numbering restarts at zero
    task automatic drop_squashed();
        expected_q.delete();
        next_seq = 0;
    endtask

    task automatic test_in_order();
        int base;
        base = commit_total;
        for (int g = 0; g < 4; g++) dispatch_group(new_entry(0), new_entry(0), 2);
        for (int s = 0; s < 8; s++) wb_todo.push_back(next_seq - 8 + s);
        writeback(1'b1);
        wait_commits(base + 8);
    endtask

    task automatic test_dual_commit();
        int base;
        int duals;
        base  = commit_total;
        duals = dual_cnt;
        // second entry is finished at write but waits behind the first
        dispatch_group(new_entry(0), new_entry(1), 2);
        wb_todo.push_back(next_seq - 2);
        writeback(1'b0);
        wait_commits(base + 2);
        expect_eq("o_commit_vld dual count", dual_cnt - duals, 1);
        dispatch_group(new_entry(1), new_entry(1), 2);
        wait_commits(base + 4);
        expect_eq("o_commit_vld dual count", dual_cnt - duals, 2);
    endtask

    task automatic test_back_pressure();
        int base;
        int first;
        base  = commit_total;
        first = next_seq;
        for (int g = 0; g < `ROB_DEPTH / `ROB_BANKS; g++) begin
            expect_true(o_can_enq, "o_can_enq low while the ROB still has room");
            dispatch_group(new_entry(0), new_entry(0), 2);
        end
        expect_eq("o_can_enq", o_can_enq, 0);
        // a request against a full ROB must leave no trace
        i_enq_vld      = 1'b1;
        i_enq_req      = '1;
        i_enq_entry[0] = new_entry(1);
        i_enq_entry[1] = new_entry(1);
        next_cycle();
        i_enq_vld = 1'b0;
        i_enq_req = '0;
        for (int s = 0; s < 4; s++) wb_todo.push_back(first + s);
        writeback(1'b0);
        wait_commits(base + 4);
        expect_eq("o_can_enq", o_can_enq, 1);
        dispatch_group(new_entry(0), new_entry(0), 2);
        for (int s = 4; s < `ROB_DEPTH + 2; s++) wb_todo.push_back(first + s);
        writeback(1'b1);
        wait_commits(base + `ROB_DEPTH + 2);
    endtask

    task automatic test_mispredict();
        int base;
        int first;
        int sq;
        base  = commit_total;
        first = next_seq;
        sq    = squash_cnt;
        for (int g = 0; g < 3; g++) dispatch_group(new_entry(0), new_entry(0), 2);
        report_spec(spec_mispred, first + 2, branch_payload(32'h0000_8a40));
        // the branch finishes last, so it is the last to retire
        wb_todo = '{first + 5, first + 4, first + 3, first + 1, first, first + 2};
        writeback(1'b0);
        wait_squash(sq + 1);
        expect_eq("commits up to the branch", commit_total - base, 3);
        expect_eq("squash delay after branch commit", squash_cycle - last_commit_cycle, 1);
        expect_eq("o_squash_info.is_except", squash_seen.is_except, 0);
        expect_eq("o_squash_info.target_pc", squash_seen.target_pc, 32'h0000_8a40);
        drop_squashed();
        repeat (3) next_cycle();
        expect_eq("commits after the squash", commit_total - base, 3);
        dispatch_group(new_entry(0), new_entry(0), 2);
        wb_todo = '{0, 1};
        writeback(1'b0);
        wait_commits(base + 5);
    endtask

    task automatic test_exception();
        int         base;
        int         first;
        int         sq;
        rob_entry_t bad;
        base  = commit_total;
        first = next_seq;
        sq    = squash_cnt;
        bad   = new_entry(0);
        dispatch_group(new_entry(0), bad, 2);
        dispatch_group(new_entry(0), new_entry(0), 2);
        report_spec(spec_except, first + 1, except_payload(5'd13));
        wb_todo = '{first + 3, first + 2, first + 1, first};
        writeback(1'b0);
        wait_squash(sq + 1);
        expect_eq("commits before the trap", commit_total - base, 1);
        expect_eq("squash delay after head reached", squash_cycle - last_commit_cycle, 2);
        expect_eq("o_squash_info.is_except", squash_seen.is_except, 1);
        expect_eq("o_squash_info.target_pc", squash_seen.target_pc, TRAP_VEC);
        expect_eq("o_squash_info.epc", squash_seen.epc, bad.pc);
        expect_eq("o_squash_info.cause", squash_seen.cause, 13);
        drop_squashed();
    endtask

    task automatic test_oldest_record();
        int base;
        int sq;
        for (int order = 0; order < 2; order++) begin
            base = commit_total;
            sq   = squash_cnt;
            dispatch_group(new_entry(0), new_entry(0), 2);
            dispatch_group(new_entry(0), new_entry(0), 2);
            if (order == 0) begin
                report_spec(spec_mispred, 3, branch_payload(32'h0000_9000));
                report_spec(spec_mispred, 1, branch_payload(32'h0000_a000));
            end else begin
                report_spec(spec_mispred, 1, branch_payload(32'h0000_a000));
                report_spec(spec_mispred, 3, branch_payload(32'h0000_9000));
            end
            wb_todo = '{0, 1, 2, 3};
            writeback(1'b0);
            wait_squash(sq + 1);
            expect_eq("commits up to the older branch", commit_total - base, 2);
            expect_eq("o_squash_info.target_pc", squash_seen.target_pc, 32'h0000_a000);
            drop_squashed();
        end
    endtask

    // retire monitor sampled mid-cycle when the commit outputs are settled
    always @(negedge clk) begin
        rob_entry_t want;
        if (!rst) begin
            expect_true((o_commit_vld & (o_commit_vld + 1'b1)) == 0,
                        "commit mask does not start at lane 0");
            for (int k = 0; k < `ROB_BANKS; k++) begin
                if (o_commit_vld[k]) begin
                    if (expected_q.size() == 0) begin
                        expect_true(1'b0, "an entry retired that was never dispatched");
                    end else begin
                        want = expected_q.pop_front();
                        expect_eq("o_commit_info.has_rd", o_commit_info[k].has_rd, want.has_rd);
                        expect_eq("o_commit_info.areg", o_commit_info[k].areg, want.areg);
                        expect_eq("o_commit_info.preg", o_commit_info[k].preg, want.preg);
                        expect_eq("o_commit_info.old_preg", o_commit_info[k].old_preg,
                                  want.old_preg);
                    end
                    commit_total++;
                    last_commit_cycle = cycle;
                end
            end
            if (&o_commit_vld) dual_cnt++;
            if (o_squash_vld) begin
                squash_cnt++;
                squash_cycle = cycle;
                squash_seen  = o_squash_info;
            end
        end
    end

    always @(posedge clk) begin
        cycle++;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        rst        = 1'b1;
        i_enq_vld  = 1'b0;
        i_enq_req  = '0;
        i_spec_wb  = '0;
        i_trap_vec = TRAP_VEC;
        for (int k = 0; k < `ROB_BANKS; k++) i_enq_entry[k] = '0;
        for (int p = 0; p < `WB_PORTS; p++) i_wb[p] = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        expect_eq("o_commit_vld", o_commit_vld, 0);
        expect_eq("o_squash_vld", o_squash_vld, 0);
        expect_eq("o_can_enq", o_can_enq, 1);
        test_in_order();
        test_dual_commit();
        test_back_pressure();
        test_mispredict();
        test_exception();
        test_oldest_record();
        next_cycle();
        $display("errors: %0d, commits: %0d, squashes: %0d", errors, commit_total, squash_cnt);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rob.f
+incdir+.
rob_pkg.sv
rob_alloc.sv
rob_bank.sv
rob_commit.sv
rob_top.sv
rob_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert -Wno-fatal
TOP       ?= rob_tb
FILELIST  ?= rob.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST)) rob_config.svh

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
